// File: design/stripe_pkg.sv
// Striping stage package with bus widths, stripe geometry and the channel payloads
package stripe_pkg;

    // Bus widths
    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 64;
    localparam int ID_W       = 4;
    localparam int LEN_W      = 8;
    localparam int RESP_W     = 2;
    localparam int REGION_W   = 4;
    localparam int BEAT_BYTES = DATA_W / 8;
    localparam int BEAT_SHIFT = $clog2(BEAT_BYTES);

    // Beat counter, holds up to 256 beats
    localparam int CNT_W = LEN_W + 1;

    // Stripe geometry
    localparam int STRIPE_BYTES = 64;
    localparam int STRIPE_SHIFT = $clog2(STRIPE_BYTES);
    localparam int STRIPE_BEATS = STRIPE_BYTES / BEAT_BYTES;
    localparam int N_CHAN       = 4;
    localparam int CHAN_W       = $clog2(N_CHAN);

    // Low address bits inside one stripe
    localparam logic [ADDR_W-1:0] STRIPE_MASK = ADDR_W'(STRIPE_BYTES - 1);

    // Sub-burst record queue
    localparam int META_DEPTH = 8;
    localparam int META_PTR_W = $clog2(META_DEPTH);

    // Response codes, ordered so that the larger value is the worse one
    localparam logic [RESP_W-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_W-1:0] RESP_EXOKAY = 2'b01;
    localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;
    localparam logic [RESP_W-1:0] RESP_DECERR = 2'b11;

    typedef logic [LEN_W-1:0]    stripe_len_t;
    typedef logic [CNT_W-1:0]    stripe_cnt_t;
    typedef logic [REGION_W-1:0] stripe_region_t;

    // Address request, AR or AW
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        stripe_len_t       len;
        logic [ID_W-1:0]   id;
        stripe_region_t    region;
    } stripe_addr_t;

    // One sub-burst record
    typedef struct packed {
        logic        last;
        stripe_len_t len;
    } stripe_meta_t;

    // Read beat
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [ID_W-1:0]   id;
        logic [RESP_W-1:0] resp;
        logic              last;
    } stripe_r_t;

    // Write beat
    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
        logic                last;
    } stripe_w_t;

    // Write response
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [RESP_W-1:0] resp;
    } stripe_b_t;

endpackage

// File: design/stripe_meta_fifo.sv
// Pointer FIFO holding sub-burst records between a splitter and its merge block
`timescale 1ns/10ps

module stripe_meta_fifo (
    input  logic                     aclk,
    input  logic                     arst_n,

    input  stripe_pkg::stripe_meta_t wr_data,
    input  logic                     wr_valid,
    output logic                     wr_ready,

    output stripe_pkg::stripe_meta_t rd_data,
    output logic                     rd_valid,
    input  logic                     rd_ready
);

    localparam int PTR_W = stripe_pkg::META_PTR_W;

    // Extra top bit tells full from empty
    logic [PTR_W:0]           wr_ptr;
    logic [PTR_W:0]           rd_ptr;
    stripe_pkg::stripe_meta_t mem [stripe_pkg::META_DEPTH];
    logic                     full;
    logic                     empty;
    logic                     push;
    logic                     pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign wr_ready = !full;
    assign rd_valid = !empty;
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;

    // Head entry shown directly
    assign rd_data = mem[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= wr_data;
        end
    end

endmodule

// File: design/stripe_split.sv
// Address splitter that cuts one burst request into stripe-aligned sub-bursts
`timescale 1ns/10ps

module stripe_split (
    input  logic                     aclk,
    input  logic                     arst_n,

    // Original request
    input  stripe_pkg::stripe_addr_t s_a,
    input  logic                     s_valid,
    output logic                     s_ready,

    // Sub-burst requests
    output stripe_pkg::stripe_addr_t m_a,
    output logic                     m_valid,
    input  logic                     m_ready,

    // Sub-burst records toward the merge block
    output stripe_pkg::stripe_meta_t meta,
    output logic                     meta_valid,
    input  logic                     meta_ready
);

    logic                          busy;
    logic [stripe_pkg::ADDR_W-1:0] cur_addr;
    logic [stripe_pkg::ID_W-1:0]   cur_id;
    // Beats still to issue, 1 to 256
    stripe_pkg::stripe_cnt_t       remain;
    stripe_pkg::stripe_cnt_t       to_bound;
    stripe_pkg::stripe_cnt_t       piece;
    logic                          piece_last;
    logic [stripe_pkg::ADDR_W-1:0] next_addr;
    logic                          accept;
    logic                          take;

    // Beats left up to the next stripe boundary
    assign to_bound = stripe_pkg::stripe_cnt_t'(stripe_pkg::STRIPE_BEATS)
                    - stripe_pkg::stripe_cnt_t'(
                          cur_addr[stripe_pkg::STRIPE_SHIFT-1:stripe_pkg::BEAT_SHIFT]);

    // Piece ends at the boundary or at the burst end
    assign piece_last = (remain <= to_bound);
    assign piece      = piece_last ? remain : to_bound;

    // First byte of the following stripe
    assign next_addr = (cur_addr | stripe_pkg::STRIPE_MASK) + 1'b1;

    // Idle splitter takes a new request
    assign s_ready = !busy;
    assign accept  = s_valid && s_ready;

    // Piece offered only while its record has room
    assign m_valid    = busy && meta_ready;
    // Record pushed together with the accepted piece
    assign meta_valid = busy && m_ready;
    assign take       = m_valid && m_ready;

    always_comb begin
        m_a.addr   = cur_addr;
        m_a.len    = stripe_pkg::stripe_len_t'(piece - 1'b1);
        m_a.id     = cur_id;
        // Channel taken from the stripe number
        m_a.region = stripe_pkg::stripe_region_t'(
                         cur_addr[stripe_pkg::STRIPE_SHIFT +: stripe_pkg::CHAN_W]);
    end

    always_comb begin
        meta.last = piece_last;
        meta.len  = m_a.len;
    end

    // Busy from request accept to the final piece
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (take && piece_last) begin
            busy <= 1'b0;
        end
    end

    // Walk address and beat count piece by piece
    always_ff @(posedge aclk) begin
        if (accept) begin
            cur_addr <= s_a.addr;
            cur_id   <= s_a.id;
            remain   <= stripe_pkg::stripe_cnt_t'(s_a.len) + 1'b1;
        end else if (take) begin
            cur_addr <= next_addr;
            remain   <= remain - piece;
        end
    end

endmodule

// File: design/stripe_rd_merge.sv
// Read merge that joins the sub-burst read data back into the original burst
`timescale 1ns/10ps

module stripe_rd_merge (
    input  logic                     aclk,
    input  logic                     arst_n,

    // Records from the read splitter
    input  stripe_pkg::stripe_meta_t meta,
    input  logic                     meta_valid,
    output logic                     meta_ready,

    // Downstream read data
    input  stripe_pkg::stripe_r_t    m_r,
    input  logic                     m_r_valid,
    output logic                     m_r_ready,

    // Upstream read data
    output stripe_pkg::stripe_r_t    s_r,
    output logic                     s_r_valid,
    input  logic                     s_r_ready
);

    stripe_pkg::stripe_meta_t head;
    logic                     head_valid;
    logic                     head_pop;

    stripe_meta_fifo i_fifo (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .wr_data  (meta),
        .wr_valid (meta_valid),
        .wr_ready (meta_ready),
        .rd_data  (head),
        .rd_valid (head_valid),
        .rd_ready (head_pop)
    );

    // No record queued means data is held back
    assign s_r_valid = m_r_valid && head_valid;
    assign m_r_ready = s_r_ready && head_valid;

    // rlast only survives on the final piece
    always_comb begin
        s_r      = m_r;
        s_r.last = m_r.last & head.last;
    end

    // Record retires with the piece's last beat
    assign head_pop = m_r_valid && m_r_ready && m_r.last;

endmodule

// File: design/stripe_wr_merge.sv
// Write merge with wlast placed per sub-burst and B responses folded per burst
`timescale 1ns/10ps

module stripe_wr_merge (
    input  logic                     aclk,
    input  logic                     arst_n,

    // Records from the write splitter
    input  stripe_pkg::stripe_meta_t meta,
    input  logic                     meta_valid,
    output logic                     meta_ready,

    // Upstream write data
    input  stripe_pkg::stripe_w_t    s_w,
    input  logic                     s_w_valid,
    output logic                     s_w_ready,

    // Downstream write data
    output stripe_pkg::stripe_w_t    m_w,
    output logic                     m_w_valid,
    input  logic                     m_w_ready,

    // Downstream responses
    input  stripe_pkg::stripe_b_t    m_b,
    input  logic                     m_b_valid,
    output logic                     m_b_ready,

    // Upstream response
    output stripe_pkg::stripe_b_t    s_b,
    output logic                     s_b_valid,
    input  logic                     s_b_ready
);

    stripe_pkg::stripe_meta_t      w_head;
    logic                          w_head_valid;
    logic                          w_head_pop;
    logic                          w_wr_ready;
    stripe_pkg::stripe_meta_t      b_head;
    logic                          b_head_valid;
    logic                          b_head_pop;
    logic                          b_wr_ready;
    stripe_pkg::stripe_len_t       beat_cnt;
    logic                          w_take;
    logic [stripe_pkg::RESP_W-1:0] acc_resp;
    logic [stripe_pkg::RESP_W-1:0] folded;
    logic                          b_take;

    // One push lands in both queues
    assign meta_ready = w_wr_ready && b_wr_ready;

    stripe_meta_fifo i_w_fifo (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .wr_data  (meta),
        .wr_valid (meta_valid && b_wr_ready),
        .wr_ready (w_wr_ready),
        .rd_data  (w_head),
        .rd_valid (w_head_valid),
        .rd_ready (w_head_pop)
    );

    stripe_meta_fifo i_b_fifo (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .wr_data  (meta),
        .wr_valid (meta_valid && w_wr_ready),
        .wr_ready (b_wr_ready),
        .rd_data  (b_head),
        .rd_valid (b_head_valid),
        .rd_ready (b_head_pop)
    );

    // W path waits for the piece record
    assign m_w_valid = s_w_valid && w_head_valid;
    assign s_w_ready = m_w_ready && w_head_valid;
    assign w_take    = m_w_valid && m_w_ready;

    // wlast rebuilt from the piece length
    always_comb begin
        m_w.data = s_w.data;
        m_w.strb = s_w.strb;
        m_w.last = (beat_cnt == w_head.len);
    end

    assign w_head_pop = w_take && m_w.last;

    // Beat index within the current piece
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt <= '0;
        end else if (w_take) begin
            beat_cnt <= m_w.last ? '0 : beat_cnt + 1'b1;
        end
    end

    // B accepted at once unless the folded B is still pending
    assign m_b_ready  = b_head_valid && !s_b_valid;
    assign b_take     = m_b_valid && m_b_ready;
    assign b_head_pop = b_take;

    // Worst response so far
    assign folded = (m_b.resp > acc_resp) ? m_b.resp : acc_resp;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            acc_resp  <= stripe_pkg::RESP_OKAY;
            s_b_valid <= 1'b0;
        end else begin
            if (b_take) begin
                // Restart the fold after the final piece
                acc_resp <= b_head.last ? stripe_pkg::RESP_OKAY : folded;
            end
            if (b_take && b_head.last) begin
                s_b_valid <= 1'b1;
            end else if (s_b_ready) begin
                s_b_valid <= 1'b0;
            end
        end
    end

    // Folded response, id from the final piece
    always_ff @(posedge aclk) begin
        if (b_take && b_head.last) begin
            s_b.id   <= m_b.id;
            s_b.resp <= folded;
        end
    end

endmodule

// File: design/axi_stripe.sv
// Address striping stage between one AXI master and an interleaved memory fabric
`timescale 1ns/10ps

module axi_stripe (
    input  logic                     aclk,
    input  logic                     arst_n,

    // Upstream, toward the master
    input  stripe_pkg::stripe_addr_t s_ar,
    input  logic                     s_ar_valid,
    output logic                     s_ar_ready,
    output stripe_pkg::stripe_r_t    s_r,
    output logic                     s_r_valid,
    input  logic                     s_r_ready,
    input  stripe_pkg::stripe_addr_t s_aw,
    input  logic                     s_aw_valid,
    output logic                     s_aw_ready,
    input  stripe_pkg::stripe_w_t    s_w,
    input  logic                     s_w_valid,
    output logic                     s_w_ready,
    output stripe_pkg::stripe_b_t    s_b,
    output logic                     s_b_valid,
    input  logic                     s_b_ready,

    // Downstream, toward the fabric
    output stripe_pkg::stripe_addr_t m_ar,
    output logic                     m_ar_valid,
    input  logic                     m_ar_ready,
    input  stripe_pkg::stripe_r_t    m_r,
    input  logic                     m_r_valid,
    output logic                     m_r_ready,
    output stripe_pkg::stripe_addr_t m_aw,
    output logic                     m_aw_valid,
    input  logic                     m_aw_ready,
    output stripe_pkg::stripe_w_t    m_w,
    output logic                     m_w_valid,
    input  logic                     m_w_ready,
    input  stripe_pkg::stripe_b_t    m_b,
    input  logic                     m_b_valid,
    output logic                     m_b_ready
);

    // Read records
    stripe_pkg::stripe_meta_t ar_meta;
    logic                     ar_meta_valid;
    logic                     ar_meta_ready;

    // Write records
    stripe_pkg::stripe_meta_t aw_meta;
    logic                     aw_meta_valid;
    logic                     aw_meta_ready;

    // AR
    stripe_split i_split_ar (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .s_a        (s_ar),
        .s_valid    (s_ar_valid),
        .s_ready    (s_ar_ready),
        .m_a        (m_ar),
        .m_valid    (m_ar_valid),
        .m_ready    (m_ar_ready),
        .meta       (ar_meta),
        .meta_valid (ar_meta_valid),
        .meta_ready (ar_meta_ready)
    );

    // R
    stripe_rd_merge i_rd_merge (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .meta       (ar_meta),
        .meta_valid (ar_meta_valid),
        .meta_ready (ar_meta_ready),
        .m_r        (m_r),
        .m_r_valid  (m_r_valid),
        .m_r_ready  (m_r_ready),
        .s_r        (s_r),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready)
    );

    // AW
    stripe_split i_split_aw (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .s_a        (s_aw),
        .s_valid    (s_aw_valid),
        .s_ready    (s_aw_ready),
        .m_a        (m_aw),
        .m_valid    (m_aw_valid),
        .m_ready    (m_aw_ready),
        .meta       (aw_meta),
        .meta_valid (aw_meta_valid),
        .meta_ready (aw_meta_ready)
    );

    // W and B
    stripe_wr_merge i_wr_merge (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .meta       (aw_meta),
        .meta_valid (aw_meta_valid),
        .meta_ready (aw_meta_ready),
        .s_w        (s_w),
        .s_w_valid  (s_w_valid),
        .s_w_ready  (s_w_ready),
        .m_w        (m_w),
        .m_w_valid  (m_w_valid),
        .m_w_ready  (m_w_ready),
        .m_b        (m_b),
        .m_b_valid  (m_b_valid),
        .m_b_ready  (m_b_ready),
        .s_b        (s_b),
        .s_b_valid  (s_b_valid),
        .s_b_ready  (s_b_ready)
    );

endmodule

// File: dv/axi_stripe_checker.sv
// Bound assertions on address hold, read last count and the origin of the folded write response
`timescale 1ns/10ps

module axi_stripe_checker (
    input logic                     aclk,
    input logic                     arst_n,
    input stripe_pkg::stripe_addr_t m_ar,
    input logic                     m_ar_valid,
    input logic                     m_ar_ready,
    input stripe_pkg::stripe_addr_t m_aw,
    input logic                     m_aw_valid,
    input logic                     m_aw_ready,
    input logic                     s_ar_valid,
    input logic                     s_ar_ready,
    input stripe_pkg::stripe_r_t    s_r,
    input logic                     s_r_valid,
    input logic                     s_r_ready,
    input logic                     s_b_valid,
    input logic                     m_b_valid,
    input logic                     m_b_ready
);

    // Upstream reads still owed an rlast
    int   rd_open;
    logic ar_take;
    logic rlast_take;

    assign ar_take    = s_ar_valid && s_ar_ready;
    assign rlast_take = s_r_valid && s_r_ready && s_r.last;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            rd_open <= 0;
        end else if (ar_take && !rlast_take) begin
            rd_open <= rd_open + 1;
        end else if (!ar_take && rlast_take) begin
            rd_open <= rd_open - 1;
        end
    end

    // Pieces held until taken
    ar_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar))
        else $error("m_ar dropped or changed before its transfer");

    aw_hold: assert property (@(posedge aclk) disable iff (!arst_n)
        m_aw_valid && !m_aw_ready |=> m_aw_valid && $stable(m_aw))
        else $error("m_aw dropped or changed before its transfer");

    // One rlast per accepted read
    rlast_once: assert property (@(posedge aclk) disable iff (!arst_n)
        rlast_take |-> rd_open > 0)
        else $error("s_r last without an open read");

    // Folded B follows a downstream B
    b_origin: assert property (@(posedge aclk) disable iff (!arst_n)
        $rose(s_b_valid) |-> $past(m_b_valid && m_b_ready))
        else $error("s_b valid without a downstream B before it");

endmodule

bind axi_stripe axi_stripe_checker i_checker (.*);

// File: dv/axi_stripe_tb.sv
// Directed testbench for the striping stage with a memory responder on the fabric side
`timescale 1ns/10ps

module axi_stripe_tb;

    // Five times the summed worst length of all tests
    localparam int TIMEOUT_CYCLES = 2000;

    logic                     aclk = 1'b0;
    logic                     arst_n;
    stripe_pkg::stripe_addr_t s_ar;
    logic                     s_ar_valid;
    logic                     s_ar_ready;
    stripe_pkg::stripe_r_t    s_r;
    logic                     s_r_valid;
    logic                     s_r_ready;
    stripe_pkg::stripe_addr_t s_aw;
    logic                     s_aw_valid;
    logic                     s_aw_ready;
    stripe_pkg::stripe_w_t    s_w;
    logic                     s_w_valid;
    logic                     s_w_ready;
    stripe_pkg::stripe_b_t    s_b;
    logic                     s_b_valid;
    logic                     s_b_ready;
    stripe_pkg::stripe_addr_t m_ar;
    logic                     m_ar_valid;
    logic                     m_ar_ready;
    stripe_pkg::stripe_r_t    m_r;
    logic                     m_r_valid;
    logic                     m_r_ready;
    stripe_pkg::stripe_addr_t m_aw;
    logic                     m_aw_valid;
    logic                     m_aw_ready;
    stripe_pkg::stripe_w_t    m_w;
    logic                     m_w_valid;
    logic                     m_w_ready;
    stripe_pkg::stripe_b_t    m_b;
    logic                     m_b_valid;
    logic                     m_b_ready;

    // Fabric side records, only appended
    stripe_pkg::stripe_addr_t ar_log[$];
    stripe_pkg::stripe_addr_t aw_log[$];
    stripe_pkg::stripe_b_t    b_log[$];
    int                       wlast_log[$];
    int                       w_beats = 0;
    int                       b_seen = 0;
    // Stripe number answered with SLVERR, -1 for none
    int                       marked_stripe = -1;
    bit                       stall = 1'b0;
    integer                   seed = 21749;
    int                       cycles = 0;

    axi_stripe i_dut (.*);

    always #50 aclk = ~aclk;

    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "simulation timed out");
        end
    end

    // Transfers seen on the fabric side
    always @(posedge aclk) begin : fabric_monitor
        stripe_pkg::stripe_addr_t piece;
        stripe_pkg::stripe_b_t    rsp;
        if (m_ar_valid && m_ar_ready) begin
            ar_log.push_back(m_ar);
        end
        if (m_aw_valid && m_aw_ready) begin
            aw_log.push_back(m_aw);
        end
        if (m_w_valid && m_w_ready) begin
            // W pieces close in AW order
            piece = aw_log[wlast_log.size()];
            // Write data is the beat's byte address, all lanes on
            compare("m_w.data", m_w.data,
                    64'(piece.addr) + 64'(w_beats * stripe_pkg::BEAT_BYTES));
            compare("m_w.strb", 64'(m_w.strb), 64'hff);
            w_beats = w_beats + 1;
            if (m_w.last) begin
                wlast_log.push_back(w_beats);
                w_beats = 0;
                rsp.id = piece.id;
                if (int'(piece.addr >> stripe_pkg::STRIPE_SHIFT) == marked_stripe) begin
                    rsp.resp = stripe_pkg::RESP_SLVERR;
                end else begin
                    rsp.resp = stripe_pkg::RESP_OKAY;
                end
                b_log.push_back(rsp);
            end
        end
        if (s_b_valid && s_b_ready) begin
            b_seen = b_seen + 1;
        end
    end

    // Downstream ready, random while stalled
    initial begin : ready_driver
        logic [31:0] rnd;
        m_ar_ready = 1'b1;
        m_aw_ready = 1'b1;
        m_w_ready  = 1'b1;
        forever begin
            @(negedge aclk);
            if (stall) begin
                rnd        = $random(seed);
                m_ar_ready = rnd[0];
                m_aw_ready = rnd[1];
                m_w_ready  = rnd[2];
            end else begin
                m_ar_ready = 1'b1;
                m_aw_ready = 1'b1;
                m_w_ready  = 1'b1;
            end
        end
    end

    // Read beats for every logged AR, in order
    initial begin : read_responder
        stripe_pkg::stripe_addr_t req;
        int                       served;
        int                       beat;
        served    = 0;
        m_r       = '0;
        m_r_valid = 1'b0;
        forever begin
            @(negedge aclk);
            if (served < ar_log.size()) begin
                req    = ar_log[served];
                served = served + 1;
                for (beat = 0; beat <= int'(req.len); beat++) begin
                    // Data is the beat's byte address
                    m_r.data  = 64'(req.addr) + 64'(beat * stripe_pkg::BEAT_BYTES);
                    m_r.id    = req.id;
                    m_r.resp  = stripe_pkg::RESP_OKAY;
                    m_r.last  = (beat == int'(req.len));
                    m_r_valid = 1'b1;
                    @(posedge aclk);
                    while (!m_r_ready) @(posedge aclk);
                    @(negedge aclk);
                end
                m_r_valid = 1'b0;
            end
        end
    end

    // One B per closed W piece
    initial begin : write_responder
        int served;
        served    = 0;
        m_b       = '0;
        m_b_valid = 1'b0;
        forever begin
            @(negedge aclk);
            if (served < b_log.size()) begin
                m_b       = b_log[served];
                served    = served + 1;
                m_b_valid = 1'b1;
                @(posedge aclk);
                while (!m_b_ready) @(posedge aclk);
                @(negedge aclk);
                m_b_valid = 1'b0;
            end
        end
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "value check failed");
        end
    endtask

    // Upstream read with every beat checked, ends on a falling edge
    task automatic read_burst(input logic [31:0] addr, input int len, input logic [3:0] id);
        int beat;
        @(negedge aclk);
        s_ar.addr   = addr;
        s_ar.len    = 8'(len);
        s_ar.id     = id;
        s_ar.region = '0;
        s_ar_valid  = 1'b1;
        @(posedge aclk);
        while (!s_ar_ready) @(posedge aclk);
        @(negedge aclk);
        s_ar_valid = 1'b0;
        beat = 0;
        while (beat <= len) begin
            @(posedge aclk);
            if (s_r_valid) begin
                compare("s_r.data", s_r.data, 64'(addr) + 64'(beat * stripe_pkg::BEAT_BYTES));
                compare("s_r.id", 64'(s_r.id), 64'(id));
                compare("s_r.resp", 64'(s_r.resp), 64'(stripe_pkg::RESP_OKAY));
                compare("s_r.last", 64'(s_r.last), 64'(beat == len));
                beat = beat + 1;
            end
        end
        @(negedge aclk);
    endtask

    // Upstream write, then one folded B with the given response
    task automatic write_burst(input logic [31:0] addr, input int len, input logic [3:0] id,
                               input logic [1:0] resp);
        int beat;
        int b_before;
        @(negedge aclk);
        b_before    = b_seen;
        s_aw.addr   = addr;
        s_aw.len    = 8'(len);
        s_aw.id     = id;
        s_aw.region = '0;
        s_aw_valid  = 1'b1;
        @(posedge aclk);
        while (!s_aw_ready) @(posedge aclk);
        @(negedge aclk);
        s_aw_valid = 1'b0;
        for (beat = 0; beat <= len; beat++) begin
            s_w.data  = 64'(addr) + 64'(beat * stripe_pkg::BEAT_BYTES);
            s_w.strb  = '1;
            s_w.last  = (beat == len);
            s_w_valid = 1'b1;
            @(posedge aclk);
            while (!s_w_ready) @(posedge aclk);
            @(negedge aclk);
        end
        s_w_valid = 1'b0;
        @(posedge aclk);
        while (!s_b_valid) @(posedge aclk);
        compare("s_b.id", 64'(s_b.id), 64'(id));
        compare("s_b.resp", 64'(s_b.resp), 64'(resp));
        // A second B would show up in these idle cycles
        repeat (4) @(negedge aclk);
        compare("s_b count", 64'(b_seen - b_before), 64'd1);
    endtask

    // Expected pieces rebuilt from the stripe rule and matched against the logs
    task automatic verify_pieces(input bit is_wr, input logic [31:0] addr, input int len,
                                 input logic [3:0] id, input int first);
        stripe_pkg::stripe_addr_t exp_q[$];
        stripe_pkg::stripe_addr_t exp_p;
        stripe_pkg::stripe_addr_t got;
        logic [31:0]              a;
        int                       left;
        int                       room;
        int                       n;
        string                    pfx;
        a    = addr;
        left = len + 1;
        while (left > 0) begin
            room         = (stripe_pkg::STRIPE_BYTES - int'(a % stripe_pkg::STRIPE_BYTES))
                         / stripe_pkg::BEAT_BYTES;
            n            = (left < room) ? left : room;
            exp_p.addr   = a;
            exp_p.len    = 8'(n - 1);
            exp_p.id     = id;
            exp_p.region = 4'((a / stripe_pkg::STRIPE_BYTES) % stripe_pkg::N_CHAN);
            exp_q.push_back(exp_p);
            a    = a + 32'(n * stripe_pkg::BEAT_BYTES);
            left = left - n;
        end
        pfx = is_wr ? "m_aw" : "m_ar";
        if (is_wr) begin
            compare("m_aw count", 64'(aw_log.size() - first), 64'(exp_q.size()));
            compare("m_w last count", 64'(wlast_log.size() - first), 64'(exp_q.size()));
        end else begin
            compare("m_ar count", 64'(ar_log.size() - first), 64'(exp_q.size()));
        end
        foreach (exp_q[i]) begin
            got = is_wr ? aw_log[first + i] : ar_log[first + i];
            compare({pfx, ".addr"}, 64'(got.addr), 64'(exp_q[i].addr));
            compare({pfx, ".len"}, 64'(got.len), 64'(exp_q[i].len));
            compare({pfx, ".id"}, 64'(got.id), 64'(exp_q[i].id));
            compare({pfx, ".region"}, 64'(got.region), 64'(exp_q[i].region));
            if (is_wr) begin
                // wlast on the piece's final beat
                compare("m_w.last beat", 64'(wlast_log[first + i]), 64'(int'(exp_q[i].len) + 1));
            end
        end
    endtask

    // Four beats inside stripe 0x43, channel 3
    task automatic read_one_stripe();
        int first;
        first = ar_log.size();
        read_burst(32'h0000_10c8, 3, 4'h2);
        verify_pieces(1'b0, 32'h0000_10c8, 3, 4'h2, first);
    endtask

    // 20 beats from two beats into a stripe, pieces of 6, 8 and 6
    task automatic read_three_pieces();
        int first;
        first = ar_log.size();
        read_burst(32'h0000_2010, 19, 4'h7);
        verify_pieces(1'b0, 32'h0000_2010, 19, 4'h7, first);
    endtask

    // 12 beats over two boundaries, pieces of 2, 8 and 2
    task automatic write_two_boundaries();
        int first;
        first = aw_log.size();
        write_burst(32'h0000_3030, 11, 4'h5, stripe_pkg::RESP_OKAY);
        verify_pieces(1'b1, 32'h0000_3030, 11, 4'h5, first);
    endtask

    // First piece lands in stripe 0x100, so the error must survive the fold
    task automatic write_marked_stripe();
        int first;
        first         = aw_log.size();
        marked_stripe = 32'h0000_4020 >> stripe_pkg::STRIPE_SHIFT;
        write_burst(32'h0000_4020, 7, 4'ha, stripe_pkg::RESP_SLVERR);
        verify_pieces(1'b1, 32'h0000_4020, 7, 4'ha, first);
        marked_stripe = -1;
    endtask

    // Same read and write as above under random downstream ready
    task automatic stalled_traffic();
        int first;
        @(posedge aclk);
        stall = 1'b1;
        first = ar_log.size();
        read_burst(32'h0000_2010, 19, 4'h7);
        verify_pieces(1'b0, 32'h0000_2010, 19, 4'h7, first);
        first = aw_log.size();
        write_burst(32'h0000_3030, 11, 4'h5, stripe_pkg::RESP_OKAY);
        verify_pieces(1'b1, 32'h0000_3030, 11, 4'h5, first);
        @(posedge aclk);
        stall = 1'b0;
    endtask

    initial begin
        arst_n     = 1'b0;
        s_ar       = '0;
        s_ar_valid = 1'b0;
        s_r_ready  = 1'b1;
        s_aw       = '0;
        s_aw_valid = 1'b0;
        s_w        = '0;
        s_w_valid  = 1'b0;
        s_b_ready  = 1'b1;
        repeat (8) @(negedge aclk);
        arst_n = 1'b1;
        read_one_stripe();
        read_three_pieces();
        write_two_boundaries();
        write_marked_stripe();
        stalled_traffic();
        repeat (4) @(negedge aclk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: axi_stripe.f
design/stripe_pkg.sv
design/stripe_meta_fifo.sv
design/stripe_split.sv
design/stripe_rd_merge.sv
design/stripe_wr_merge.sv
design/axi_stripe.sv
dv/axi_stripe_checker.sv
dv/axi_stripe_tb.sv

// File: Makefile
SIM := obj_dir/Vaxi_stripe_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): axi_stripe.f $(wildcard design/*.sv dv/*.sv)
	verilator --binary --assert -f axi_stripe.f --top-module axi_stripe_tb -o Vaxi_stripe_tb

# Pass only when the log holds the pass line
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
